// ==== src/dbg_config.svh ====
`ifndef DBG_CONFIG_SVH
`define DBG_CONFIG_SVH

////////////////////////////////////////
// console sizes
////////////////////////////////////////

// data word and address width
`define DBG_WORD_W 32
// registers listed by R
`define DBG_NREGS 32
// words listed by D
`define DBG_DUMP_WORDS 8

`endif

// ==== src/dbg_char_pkg.sv ====
package dbg_char_pkg;

    // one character on either stream
    typedef logic [7:0] byte_t;

    ////////////////////////////////////////
    // request kinds
    ////////////////////////////////////////

    typedef enum logic
    {
        SCAN_CHAR,      // one raw byte
        SCAN_HEX        // hex word up to the first non-digit
    } scan_kind_t;

    typedef enum logic
    {
        PRINT_CHAR,     // one byte as is
        PRINT_HEX       // eight upper case digits
    } print_kind_t;

    ////////////////////////////////////////
    // named characters
    ////////////////////////////////////////

    localparam byte_t CH_SPACE = 8'h20;
    localparam byte_t CH_CR    = 8'h0d;
    localparam byte_t CH_NL    = 8'h0a;
    localparam byte_t CH_QUERY = 8'h3f;

endpackage

// ==== src/dbg_cmd_pkg.sv ====
package dbg_cmd_pkg;

    ////////////////////////////////////////
    // command letters
    ////////////////////////////////////////

    typedef enum logic [7:0]
    {
        CMD_R = 8'h52,  // register dump
        CMD_D = 8'h44   // memory dump
    } cmd_t;

    ////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////

    typedef enum logic [1:0]
    {
        CS_FETCH,       // waiting for a command letter
        CS_UNKNOWN,     // answering with ?
        CS_RUN          // a dump unit is busy
    } ctrl_state_t;

    // owner of the shared scanner and printer
    typedef enum logic [1:0]
    {
        MODE_NONE,
        MODE_R,
        MODE_D
    } mode_t;

endpackage

// ==== src/dbg_if.sv ====
`include "dbg_config.svh"
`timescale 1ns/1ns

////////////////////////////////////////
// scanner request channel
////////////////////////////////////////
interface scan_if import dbg_char_pkg::*; ();
    logic                   req;
    scan_kind_t             kind;
    logic                   ack;
    // char in the low byte, or the parsed word
    logic [`DBG_WORD_W-1:0] data;
    // word was ended by cr or nl
    logic                   term;

    modport client
    (
        output req, kind,
        input  ack, data, term
    );
    modport server
    (
        input  req, kind,
        output ack, data, term
    );
endinterface

////////////////////////////////////////
// printer request channel
////////////////////////////////////////
interface print_if import dbg_char_pkg::*; ();
    logic                   req;
    print_kind_t            kind;
    // char in the low byte, or the whole word
    logic [`DBG_WORD_W-1:0] data;
    logic                   ack;

    modport client
    (
        output req, kind, data,
        input  ack
    );
    modport server
    (
        input  req, kind, data,
        output ack
    );
endinterface

// ==== src/cmd_scanner.sv ====
`include "dbg_config.svh"
`timescale 1ns/1ns

module cmd_scanner import dbg_char_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  byte_t  rx_data,
    input  logic   rx_valid,
    output logic   rx_ready,
    scan_if.server scan
);
    localparam int W = `DBG_WORD_W;

    logic [W-1:0] acc;
    logic         started;
    logic         is_hex;
    logic [3:0]   nib;
    logic         take;

    // pull bytes only for an open request, never in its ack cycle or in reset
    assign rx_ready  = rstn && scan.req && !scan.ack;
    assign take      = rx_ready && rx_valid;
    assign scan.data = acc;

    // hex digit decode, either case
    always_comb
    begin
        is_hex = 1'b1;
        nib    = rx_data[3:0];
        if (rx_data >= 8'h30 && rx_data <= 8'h39)
            nib = rx_data[3:0];
        else if ((rx_data >= 8'h41 && rx_data <= 8'h46) ||
                 (rx_data >= 8'h61 && rx_data <= 8'h66))
            nib = rx_data[3:0] + 4'd9;
        else
            is_hex = 1'b0;
    end

    ////////////////////////////////////////
    // handshake and word end
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            scan.ack  <= 1'b0;
            scan.term <= 1'b0;
            started   <= 1'b0;
        end
        else
        begin
            scan.ack <= 1'b0;
            if (scan.ack)
                started <= 1'b0;
            else if (take)
            begin
                if (scan.kind == SCAN_CHAR)
                begin
                    scan.ack  <= 1'b1;
                    scan.term <= 1'b0;
                end
                else if (is_hex)
                    started <= 1'b1;
                else if (!(rx_data == CH_SPACE && !started))
                begin
                    // first non-digit closes the word
                    scan.ack  <= 1'b1;
                    scan.term <= (rx_data == CH_NL) || (rx_data == CH_CR);
                end
            end
        end
    end

    // accumulator, emptied once the word is handed over
    always_ff @(posedge clk)
    begin
        if (scan.ack)
            acc <= '0;
        else if (take && scan.kind == SCAN_CHAR)
            acc <= W'(rx_data);
        else if (take && is_hex)
            acc <= {acc[W-5:0], nib};
    end

endmodule

// ==== src/hex_printer.sv ====
`include "dbg_config.svh"
`timescale 1ns/1ns

module hex_printer import dbg_char_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    print_if.server print,
    output byte_t   tx_data,
    output logic    tx_valid,
    input  logic    tx_ready
);
    localparam int W    = `DBG_WORD_W;
    localparam int NDIG = W / 4;
    localparam int CW   = $clog2(NDIG);

    logic [W-1:0]  shift;
    logic          hex_mode;
    logic [CW-1:0] left;
    logic          busy;
    logic [3:0]    nib;
    logic          load;
    logic          step;

    // new item only when idle and not in the ack cycle
    assign load     = !busy && print.req && !print.ack;
    assign step     = busy && tx_ready;
    assign tx_valid = busy;
    // top nibble goes out first
    assign nib      = shift[W-1 -: 4];

    always_comb
    begin
        if (!hex_mode)
            tx_data = shift[7:0];
        else if (nib < 4'd10)
            tx_data = 8'h30 + {4'h0, nib};
        else
            tx_data = 8'h37 + {4'h0, nib};   // 'A' minus ten
    end

    ////////////////////////////////////////
    // item handshake
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            busy      <= 1'b0;
            print.ack <= 1'b0;
        end
        else
        begin
            print.ack <= 1'b0;
            if (load)
                busy <= 1'b1;
            else if (step && left == '0)
            begin
                // last byte just left
                busy      <= 1'b0;
                print.ack <= 1'b1;
            end
        end
    end

    // payload and digit count
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            shift    <= print.data;
            hex_mode <= (print.kind == PRINT_HEX);
            left     <= (print.kind == PRINT_HEX) ? CW'(NDIG - 1) : '0;
        end
        else if (step)
        begin
            shift <= shift << 4;
            left  <= left - 1'b1;
        end
    end

endmodule

// ==== src/reg_dump_unit.sv ====
`include "dbg_config.svh"
`timescale 1ns/1ns

module reg_dump_unit import dbg_char_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start,
    output logic                   done,
    print_if.client                print,
    output logic [4:0]             rf_addr,
    input  logic [`DBG_WORD_W-1:0] rf_data
);
    localparam int W = `DBG_WORD_W;

    logic [4:0] idx;
    logic       busy;
    logic       nl_phase;

    assign rf_addr    = idx;
    // word of the current register, then its newline
    assign print.req  = busy;
    assign print.kind = nl_phase ? PRINT_CHAR : PRINT_HEX;
    assign print.data = nl_phase ? W'(CH_NL) : rf_data;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            busy     <= 1'b0;
            nl_phase <= 1'b0;
            idx      <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy     <= 1'b1;
                nl_phase <= 1'b0;
                idx      <= '0;
            end
            else if (busy && print.ack)
            begin
                nl_phase <= !nl_phase;
                if (nl_phase && idx == 5'(`DBG_NREGS - 1))
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                else if (nl_phase)
                    idx <= idx + 1'b1;
            end
        end
    end

endmodule

// ==== src/mem_dump_unit.sv ====
`include "dbg_config.svh"
`timescale 1ns/1ns

module mem_dump_unit import dbg_char_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start,
    output logic                   done,
    scan_if.client                 scan,
    print_if.client                print,
    output logic [`DBG_WORD_W-1:0] dm_addr,
    input  logic [`DBG_WORD_W-1:0] dm_data
);
    localparam int W  = `DBG_WORD_W;
    localparam int CW = $clog2(`DBG_DUMP_WORDS);

    // steps of one dump line
    typedef enum logic [2:0]
    {
        MD_IDLE,
        MD_SCAN,
        MD_ADDR,
        MD_SP,
        MD_WORD,
        MD_NL
    } md_state_t;

    md_state_t     state;
    logic [W-1:0]  addr;
    logic [CW-1:0] cnt;

    assign dm_addr   = addr;
    // argument is always a hex word
    assign scan.req  = (state == MD_SCAN);
    assign scan.kind = SCAN_HEX;

    always_comb
    begin
        print.req  = 1'b1;
        print.kind = PRINT_CHAR;
        print.data = W'(CH_NL);
        case (state)
            MD_ADDR:
            begin
                print.kind = PRINT_HEX;
                print.data = addr;
            end
            MD_SP:
                print.data = W'(CH_SPACE);
            MD_WORD:
            begin
                print.kind = PRINT_HEX;
                print.data = dm_data;
            end
            MD_NL:
                print.req = 1'b1;
            default:
                print.req = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // line sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= MD_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                MD_IDLE:
                    if (start)
                    begin
                        state <= MD_SCAN;
                        cnt   <= '0;
                    end
                MD_SCAN:
                    if (scan.ack)
                        state <= MD_ADDR;
                MD_ADDR:
                    if (print.ack)
                        state <= MD_SP;
                MD_SP:
                    if (print.ack)
                        state <= MD_WORD;
                MD_WORD:
                    if (print.ack)
                        state <= MD_NL;
                MD_NL:
                    if (print.ack && cnt == CW'(`DBG_DUMP_WORDS - 1))
                    begin
                        state <= MD_IDLE;
                        done  <= 1'b1;
                    end
                    else if (print.ack)
                    begin
                        cnt   <= cnt + 1'b1;
                        state <= MD_ADDR;
                    end
                default:
                    state <= MD_IDLE;
            endcase
        end
    end

    // base from the argument, then one word per line
    always_ff @(posedge clk)
    begin
        if (state == MD_SCAN && scan.ack)
            addr <= scan.data;
        else if (state == MD_NL && print.ack)
            addr <= addr + W'(4);
    end

endmodule

// ==== src/dbg_ctrl.sv ====
`include "dbg_config.svh"
`timescale 1ns/1ns

module dbg_ctrl import dbg_char_pkg::*, dbg_cmd_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    scan_if.client                 scan,
    print_if.client                print,
    output logic [4:0]             rf_addr,
    input  logic [`DBG_WORD_W-1:0] rf_data,
    output logic [`DBG_WORD_W-1:0] dm_addr,
    input  logic [`DBG_WORD_W-1:0] dm_data
);
    localparam int W = `DBG_WORD_W;

    ctrl_state_t state;
    mode_t       mode;
    logic        unk_nl;
    logic        start_r;
    logic        start_d;
    logic        done_r;
    logic        done_d;
    byte_t       ch;

    // unit side channels
    print_if rd_print ();
    scan_if  md_scan ();
    print_if md_print ();

    assign ch = scan.data[7:0];

    ////////////////////////////////////////
    // command FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state   <= CS_FETCH;
            mode    <= MODE_NONE;
            unk_nl  <= 1'b0;
            start_r <= 1'b0;
            start_d <= 1'b0;
        end
        else
        begin
            start_r <= 1'b0;
            start_d <= 1'b0;
            case (state)
                CS_FETCH:
                    if (scan.ack)
                    begin
                        case (ch)
                            CH_SPACE, CH_CR, CH_NL:
                                state <= CS_FETCH;
                            CMD_R:
                            begin
                                mode    <= MODE_R;
                                start_r <= 1'b1;
                                state   <= CS_RUN;
                            end
                            CMD_D:
                            begin
                                mode    <= MODE_D;
                                start_d <= 1'b1;
                                state   <= CS_RUN;
                            end
                            default:
                                state <= CS_UNKNOWN;
                        endcase
                    end
                CS_UNKNOWN:
                    // ? first, then the newline
                    if (print.ack)
                    begin
                        unk_nl <= !unk_nl;
                        if (unk_nl)
                            state <= CS_FETCH;
                    end
                CS_RUN:
                    if (done_r || done_d)
                    begin
                        state <= CS_FETCH;
                        mode  <= MODE_NONE;
                    end
                default:
                    state <= CS_FETCH;
            endcase
        end
    end

    ////////////////////////////////////////
    // mode mux onto scanner and printer
    ////////////////////////////////////////
    always_comb
    begin
        // the FSM itself owns both by default
        scan.req      = (state == CS_FETCH);
        scan.kind     = SCAN_CHAR;
        print.req     = (state == CS_UNKNOWN);
        print.kind    = PRINT_CHAR;
        print.data    = W'(unk_nl ? CH_NL : CH_QUERY);
        rd_print.ack  = 1'b0;
        md_print.ack  = 1'b0;
        md_scan.ack   = 1'b0;
        md_scan.data  = scan.data;
        md_scan.term  = scan.term;
        case (mode)
            MODE_R:
            begin
                print.req    = rd_print.req;
                print.kind   = rd_print.kind;
                print.data   = rd_print.data;
                rd_print.ack = print.ack;
            end
            MODE_D:
            begin
                scan.req     = md_scan.req;
                scan.kind    = md_scan.kind;
                md_scan.ack  = scan.ack;
                print.req    = md_print.req;
                print.kind   = md_print.kind;
                print.data   = md_print.data;
                md_print.ack = print.ack;
            end
            default:
                scan.kind = SCAN_CHAR;
        endcase
    end

    reg_dump_unit rd_i
    (
        .clk     (clk),
        .rstn    (rstn),
        .start   (start_r),
        .done    (done_r),
        .print   (rd_print),
        .rf_addr (rf_addr),
        .rf_data (rf_data)
    );

    mem_dump_unit md_i
    (
        .clk     (clk),
        .rstn    (rstn),
        .start   (start_d),
        .done    (done_d),
        .scan    (md_scan),
        .print   (md_print),
        .dm_addr (dm_addr),
        .dm_data (dm_data)
    );

endmodule

// ==== src/dbg_console_top.sv ====
`include "dbg_config.svh"
`timescale 1ns/1ns

module dbg_console_top import dbg_char_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    // host command stream
    input  byte_t                  rx_data,
    input  logic                   rx_valid,
    output logic                   rx_ready,
    // console text stream
    output byte_t                  tx_data,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    // cpu read ports
    output logic [4:0]             rf_addr,
    input  logic [`DBG_WORD_W-1:0] rf_data,
    output logic [`DBG_WORD_W-1:0] dm_addr,
    input  logic [`DBG_WORD_W-1:0] dm_data
);
    scan_if  scan_bus ();
    print_if print_bus ();

    // bytes in
    cmd_scanner scanner_i
    (
        .clk      (clk),
        .rstn     (rstn),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .scan     (scan_bus)
    );

    // bytes out
    hex_printer printer_i
    (
        .clk      (clk),
        .rstn     (rstn),
        .print    (print_bus),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    dbg_ctrl ctrl_i
    (
        .clk     (clk),
        .rstn    (rstn),
        .scan    (scan_bus),
        .print   (print_bus),
        .rf_addr (rf_addr),
        .rf_data (rf_data),
        .dm_addr (dm_addr),
        .dm_data (dm_data)
    );

endmodule

// ==== sim/dbg_console_sva.sv ====
`timescale 1ns/1ns

module dbg_console_sva import dbg_char_pkg::*;
(
    input logic  clk,
    input logic  rstn,
    input logic  rx_ready,
    input byte_t tx_data,
    input logic  tx_valid,
    input logic  tx_ready
);

    ////////////////////////////////////////
    // tx stream rules
    ////////////////////////////////////////

    // stalled byte stays on the bus
    tx_data_hold: assert property (@(posedge clk) disable iff (!rstn)
        tx_valid && !tx_ready |=> $stable(tx_data))
    else $error("tx_data changed while the host stalled it");

    // valid drops only after a transfer
    tx_valid_hold: assert property (@(posedge clk) disable iff (!rstn)
        tx_valid && !tx_ready |=> tx_valid)
    else $error("tx_valid dropped before the byte was taken");

    // no unknown byte on a valid cycle
    tx_data_known: assert property (@(posedge clk) disable iff (!rstn)
        tx_valid |-> !$isunknown(tx_data))
    else $error("tx_data unknown while tx_valid is high");

    // output quiet in reset
    tx_reset_quiet: assert property (@(posedge clk)
        !rstn |-> !tx_valid)
    else $error("tx_valid high during reset");

    // no byte taken in reset
    rx_reset_quiet: assert property (@(posedge clk)
        !rstn |-> !rx_ready)
    else $error("rx_ready high during reset");

endmodule

bind dbg_console_top dbg_console_sva sva_i
(
    .clk      (clk),
    .rstn     (rstn),
    .rx_ready (rx_ready),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready)
);

// ==== sim/dbg_console_tb.sv ====
`include "dbg_config.svh"
`timescale 1ns/1ns

module dbg_console_tb import dbg_char_pkg::*; ();
    localparam int W          = `DBG_WORD_W;
    localparam int NREGS      = `DBG_NREGS;
    localparam int NWORDS     = `DBG_DUMP_WORDS;
    localparam int DMEM_DEPTH = 256;
    // R under back-pressure is the longest test, well below 50 us
    localparam int LONGEST_TEST_NS = 50000;
    localparam int WATCHDOG_NS     = 4 * LONGEST_TEST_NS;

    logic         clk;
    logic         rstn;
    byte_t        rx_data;
    logic         rx_valid;
    logic         rx_ready;
    byte_t        tx_data;
    logic         tx_valid;
    logic         tx_ready;
    logic [4:0]   rf_addr;
    logic [W-1:0] rf_data;
    logic [W-1:0] dm_addr;
    logic [W-1:0] dm_data;

    // cpu side models
    logic [W-1:0] regs [NREGS];
    logic [W-1:0] dmem [DMEM_DEPTH];
    integer       seed;
    int           errors;
    // random tx_ready when set
    logic         stall_mode;
    // text lines received for the current command
    string        lines [$];

    initial
        clk = 1'b0;
    always #4 clk = ~clk;

    // combinational read ports
    assign rf_data = regs[rf_addr];
    assign dm_data = dmem[dm_addr[9:2]];

    dbg_console_top dut_i
    (
        .clk      (clk),
        .rstn     (rstn),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rf_addr  (rf_addr),
        .rf_data  (rf_data),
        .dm_addr  (dm_addr),
        .dm_data  (dm_data)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // eight upper case digits, top digit first
    function automatic string hex_word(input logic [W-1:0] value);
        string digits;
        string s;
        int    n;
        digits = "0123456789ABCDEF";
        s      = "";
        for (int i = W / 4 - 1; i >= 0; i--)
        begin
            n = int'(value[i*4 +: 4]);
            s = {s, digits.substr(n, n)};
        end
        return s;
    endfunction

    // host side, one byte at a time
    task automatic send_text(input string text);
        for (int i = 0; i < text.len(); i++)
        begin
            @(negedge clk);
            rx_data  = text[i];
            rx_valid = 1'b1;
            // hold the byte until the console takes it
            while (!rx_ready)
                @(negedge clk);
            @(negedge clk);
            rx_valid = 1'b0;
        end
    endtask

    // gathers tx bytes into lines until count newlines came
    task automatic collect_lines(input int count);
        string cur;
        cur = "";
        lines.delete();
        while (lines.size() < count)
        begin
            @(negedge clk);
            if (stall_mode)
                tx_ready = ($random(seed) & 32'd1) != 0;
            else
                tx_ready = 1'b1;
            // byte goes at the coming rising edge
            if (tx_valid && tx_ready)
            begin
                if (tx_data == CH_NL)
                begin
                    lines.push_back(cur);
                    cur = "";
                end
                else
                    cur = $sformatf("%s%c", cur, tx_data);
            end
        end
        @(negedge clk);
        tx_ready = 1'b0;
    endtask

    task automatic check_line(input int idx, input string expected);
        assert (lines[idx] == expected)
        else
        begin
            errors++;
            $display("FAILED at %0t ns: line %0d is \"%s\", expected \"%s\"",
                     $time, idx, lines[idx], expected);
        end
    endtask

    // dump lines start at first, address steps by 4
    task automatic check_mem_lines(input int first, input logic [W-1:0] base);
        logic [W-1:0] a;
        for (int i = 0; i < NWORDS; i++)
        begin
            a = base + W'(4 * i);
            check_line(first + i, {hex_word(a), " ", hex_word(dmem[a[9:2]])});
        end
    endtask

    // nothing more may come once the text is complete
    task automatic check_quiet();
        repeat (12) @(negedge clk);
        assert (!tx_valid)
        else
        begin
            errors++;
            $display("console sent more text than expected at %0t ns", $time);
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reg_dump(input string cmd);
        fork
            send_text(cmd);
            collect_lines(NREGS);
        join
        for (int i = 0; i < NREGS; i++)
            check_line(i, hex_word(regs[i]));
        check_quiet();
    endtask

    task automatic test_mem_dump(input string cmd, input logic [W-1:0] base);
        fork
            send_text(cmd);
            collect_lines(NWORDS);
        join
        check_mem_lines(0, base);
        check_quiet();
    endtask

    // unknown letter, then a dump that must still work
    task automatic test_unknown();
        fork
            send_text("ZD 0\n");
            collect_lines(1 + NWORDS);
        join
        check_line(0, "?");
        check_mem_lines(1, '0);
        check_quiet();
    endtask

    initial
    begin
        seed       = 32'h66d9_9f5b;
        errors     = 0;
        stall_mode = 1'b0;
        rstn       = 1'b0;
        rx_data    = '0;
        rx_valid   = 1'b0;
        tx_ready   = 1'b0;
        for (int i = 0; i < NREGS; i++)
            regs[i] = $random(seed);
        for (int i = 0; i < DMEM_DEPTH; i++)
            dmem[i] = $random(seed);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        test_reg_dump("R\n");
        test_mem_dump("D 40\n", 32'h40);
        test_mem_dump("D1aC\n", 32'h1ac);
        test_unknown();
        // leading whitespace, host stalls tx at random
        stall_mode = 1'b1;
        test_reg_dump(" \n  R\n");
        stall_mode = 1'b0;

        $display("checks done, %0d error(s)", errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, a test never finished", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+src
src/dbg_char_pkg.sv
src/dbg_cmd_pkg.sv
src/dbg_if.sv
src/cmd_scanner.sv
src/hex_printer.sv
src/reg_dump_unit.sv
src/mem_dump_unit.sv
src/dbg_ctrl.sv
src/dbg_console_top.sv
sim/dbg_console_sva.sv
sim/dbg_console_tb.sv

// ==== Makefile ====
# Verilator build and run for the debug console

VERILATOR  ?= verilator
TOP        := dbg_console_tb
FILELIST   := project.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

# the run passes only if the testbench reports a clean result
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
